/* Makefile */
TOP := tb_soc_bus

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f files.f

obj_dir/V$(TOP): files.f $(wildcard src/*.sv bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module $(TOP) -f files.f

# The run passes only if the log holds the pass message
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_soc_bus.sv */
// Parameters must match the DUT instance; SRAM bytes never written are masked out of read checks
`timescale 1ns/1ps

module tb_soc_bus;

  localparam int unsigned SramWords  = 256;
  localparam int unsigned NumScratch = 4;
  localparam int unsigned SramAw     = $clog2(SramWords);
  localparam int unsigned ScrAw      = $clog2(NumScratch);
  localparam logic [31:0] ChipIdVal  = 32'hC0C0_0001;
  localparam logic [31:0] ErrVal     = 32'hBADC_AB1E;
  localparam int          WaitLimit  = 50;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        req_i;
  logic        we_i;
  logic [3:0]  be_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic        fetch_en_i;
  logic        gnt_o;
  logic        rvalid_o;
  logic [31:0] rdata_o;
  logic        err_o;
  logic        fetch_en_o;

  // ------------------------------
  // Reference model
  // ------------------------------
  logic [31:0] sram_model [SramWords];
  logic [3:0]  sram_known [SramWords];
  logic [31:0] scratch_model [NumScratch];
  logic        fetch_model;
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          cycle_cnt;

  // Expected responses, oldest first
  int          exp_due [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_mask [$];
  logic        exp_err [$];
  string       exp_name [$];

  soc_bus_top #(
    .SramWords  ( SramWords  ),
    .NumScratch ( NumScratch )
  ) uut (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .req_i      ( req_i      ),
    .we_i       ( we_i       ),
    .be_i       ( be_i       ),
    .addr_i     ( addr_i     ),
    .wdata_i    ( wdata_i    ),
    .fetch_en_i ( fetch_en_i ),
    .gnt_o      ( gnt_o      ),
    .rvalid_o   ( rvalid_o   ),
    .rdata_o    ( rdata_o    ),
    .err_o      ( err_o      ),
    .fetch_en_o ( fetch_en_o )
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Two LCG steps, upper halves only
  function automatic logic [31:0] rand_word();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    hi        = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {hi, lcg_state[31:16]};
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return rand_word() % n;
  endfunction

  function automatic logic [31:0] sram_addr(input int unsigned idx);
    return {8'h10, 22'(idx), 2'b00};
  endfunction

  function automatic logic [31:0] ctrl_addr(input int unsigned off);
    return {8'h03, 22'(off), 2'b00};
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("FAIL %s: %s expected %08h actual %08h", name, what, exp, act);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic pop_expected();
    void'(exp_due.pop_front());
    void'(exp_data.pop_front());
    void'(exp_mask.pop_front());
    void'(exp_err.pop_front());
    void'(exp_name.pop_front());
  endtask

  task automatic check_fetch_en(input string name);
    checks++;
    if (fetch_en_o !== (fetch_en_i | fetch_model)) begin
      report_mismatch(name, "fetch_en_o", 32'(fetch_en_i | fetch_model), 32'(fetch_en_o));
    end
  endtask

  // Called 1 ns after a rising edge, returns at the same point of the next one
  task automatic set_fetch_pin(input logic pin, input string name);
    fetch_en_i = pin;
    #1;
    check_fetch_en(name);
    @(posedge clk_i);
    #1;
  endtask

  // ------------------------------
  // One bus access
  // ------------------------------
  task automatic access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                        input logic [31:0] wdata, input string name);
    int unsigned       off;
    logic [SramAw-1:0] sidx;
    logic [ScrAw-1:0]  cidx;
    logic [31:0]       data;
    logic [31:0]       mask;
    logic              err;
    logic              accepted;
    int                waited;
    int                b;
    off  = 32'(addr[23:2]);
    sidx = SramAw'(off);
    cidx = ScrAw'(off - 2);
    data = 32'h0;
    mask = 32'hFFFF_FFFF;
    err  = 1'b0;
    if (addr[1:0] == 2'b00 && addr[31:24] == 8'h10 && off < SramWords) begin
      for (b = 0; b < 4; b++) begin
        if (we && be[b]) begin
          sram_model[sidx][8*b +: 8] = wdata[8*b +: 8];
          sram_known[sidx][b]        = 1'b1;
        end
        if (!we) begin
          mask[8*b +: 8] = {8{sram_known[sidx][b]}};
        end
      end
      if (!we) begin
        data = sram_model[sidx];
      end
    end else if (addr[1:0] == 2'b00 && addr[31:24] == 8'h03 && off < 2 + NumScratch) begin
      if (we && off == 1 && be[0]) begin
        fetch_model = wdata[0];
      end
      for (b = 0; b < 4; b++) begin
        if (we && off >= 2 && be[b]) begin
          scratch_model[cidx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      if (!we) begin
        data = (off == 0) ? ChipIdVal : (off == 1) ? {31'h0, fetch_model} : scratch_model[cidx];
      end
    end else begin
      err  = 1'b1;
      data = ErrVal;
    end
    req_i    = 1'b1;
    we_i     = we;
    be_i     = be;
    addr_i   = addr;
    wdata_i  = wdata;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < WaitLimit) begin
      @(posedge clk_i);
      accepted = gnt_o;
      waited++;
    end
    #1;
    if (!accepted) begin
      report_problem($sformatf("%s was not granted within %0d cycles", name, WaitLimit));
      req_i = 1'b0;
    end else begin
      exp_due.push_back(cycle_cnt);
      exp_data.push_back(data);
      exp_mask.push_back(mask);
      exp_err.push_back(err);
      exp_name.push_back(name);
    end
  endtask

  // Idle the bus until every outstanding response is checked
  task automatic drain();
    int waited;
    req_i  = 1'b0;
    waited = 0;
    while (exp_due.size() != 0 && waited < WaitLimit) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_due.size() != 0) begin
      report_problem($sformatf("%0d responses still missing after timeout", exp_due.size()));
      while (exp_due.size() != 0) begin
        pop_expected();
      end
    end
  endtask

  // ------------------------------
  // Response checker, mid-cycle
  // ------------------------------
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      checks++;
      if (rvalid_o !== 1'b0) begin
        report_problem("rvalid_o is high during reset");
      end
    end else if (rvalid_o === 1'b1) begin
      if (exp_due.size() == 0) begin
        report_problem($sformatf("response at cycle %0d with no request outstanding", cycle_cnt));
      end else begin
        checks++;
        if (exp_due[0] != cycle_cnt) begin
          report_problem($sformatf("%s answered at cycle %0d instead of cycle %0d",
                                   exp_name[0], cycle_cnt, exp_due[0]));
        end
        if (err_o !== exp_err[0]) begin
          report_mismatch(exp_name[0], "err", 32'(exp_err[0]), 32'(err_o));
        end
        if ((rdata_o & exp_mask[0]) !== (exp_data[0] & exp_mask[0])) begin
          report_mismatch(exp_name[0], "rdata", exp_data[0] & exp_mask[0], rdata_o & exp_mask[0]);
        end
        pop_expected();
      end
    end else if (exp_due.size() != 0 && exp_due[0] <= cycle_cnt) begin
      report_problem($sformatf("no response for %s at cycle %0d", exp_name[0], cycle_cnt));
      pop_expected();
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    int          i;
    int          k;
    logic [31:0] r;
    lcg_state     = 32'd51698;
    errors        = 0;
    checks        = 0;
    cycle_cnt     = 0;
    fetch_model   = 1'b0;
    sram_known    = '{default: 4'h0};
    scratch_model = '{default: 32'h0};
    rst_n_i       = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    be_i          = 4'h0;
    addr_i        = 32'h0;
    wdata_i       = 32'h0;
    fetch_en_i    = 1'b0;

    // Reset with the fetch-enable pin toggling
    for (i = 0; i < 10; i++) begin
      @(posedge clk_i);
      #1;
      r          = rand_word();
      fetch_en_i = r[0];
      #1;
      check_fetch_en("reset_fetch_pin");
    end
    rst_n_i    = 1'b1;
    fetch_en_i = 1'b0;
    @(posedge clk_i);
    #1;
    access(1'b0, 4'hF, ctrl_addr(1), 32'h0, "reset_fetch_reg");
    for (k = 0; k < NumScratch; k++) begin
      access(1'b0, 4'hF, ctrl_addr(2 + k), 32'h0, "reset_scratch");
    end
    drain();

    // SRAM, random byte-enabled writes over a small window
    for (i = 0; i < 64; i++) begin
      r = rand_word();
      access(1'b1, r[3:0], sram_addr(rand_below(32)), rand_word(), "sram_write");
    end
    access(1'b1, 4'hF, sram_addr(SramWords - 1), rand_word(), "sram_write_last");
    for (k = 0; k < 32; k++) begin
      access(1'b0, 4'hF, sram_addr(k), 32'h0, "sram_read");
    end
    access(1'b0, 4'hF, sram_addr(SramWords - 1), 32'h0, "sram_read_last");
    drain();

    // Control registers
    access(1'b1, 4'hF, ctrl_addr(0), rand_word(), "id_write");
    access(1'b0, 4'hF, ctrl_addr(0), 32'h0, "id_read");
    for (k = 0; k < NumScratch; k++) begin
      r = rand_word();
      access(1'b1, 4'hF, ctrl_addr(2 + k), rand_word(), "scratch_fill");
      access(1'b1, r[3:0], ctrl_addr(2 + k), rand_word(), "scratch_bytes");
      access(1'b0, 4'hF, ctrl_addr(2 + k), 32'h0, "scratch_read");
    end
    access(1'b1, 4'h1, ctrl_addr(1), 32'h1, "fetch_set");
    drain();
    set_fetch_pin(1'b0, "fetch_reg_pin_low");
    set_fetch_pin(1'b1, "fetch_reg_pin_high");
    access(1'b0, 4'hF, ctrl_addr(1), 32'h0, "fetch_read");
    access(1'b1, 4'h1, ctrl_addr(1), 32'h0, "fetch_clear");
    drain();
    set_fetch_pin(1'b1, "fetch_pin_high");
    set_fetch_pin(1'b0, "fetch_pin_low");

    // Error responses change no state
    access(1'b1, 4'hF, sram_addr(5), rand_word(), "err_setup");
    access(1'b1, 4'hF, sram_addr(0), rand_word(), "err_setup");
    r = rand_word();
    access(1'b1, 4'hF, {8'h20, r[23:2], 2'b00}, rand_word(), "err_unmapped");
    access(1'b1, 4'hF, sram_addr(5) + 32'd1, rand_word(), "err_misaligned");
    access(1'b0, 4'hF, sram_addr(5) + 32'd3, 32'h0, "err_misaligned_read");
    access(1'b1, 4'hF, sram_addr(SramWords), rand_word(), "err_sram_range");
    access(1'b1, 4'hF, ctrl_addr(2 + NumScratch), rand_word(), "err_ctrl_range");
    access(1'b1, 4'h1, ctrl_addr(1) + 32'd2, 32'h1, "err_fetch_misaligned");
    access(1'b0, 4'hF, sram_addr(5), 32'h0, "err_after_sram5");
    access(1'b0, 4'hF, sram_addr(0), 32'h0, "err_after_sram0");
    access(1'b0, 4'hF, ctrl_addr(1), 32'h0, "err_after_fetch");
    access(1'b0, 4'hF, ctrl_addr(2), 32'h0, "err_after_scratch");
    drain();
    check_fetch_en("err_fetch_pin");

    // Back-to-back random mix
    for (i = 0; i < 200; i++) begin
      r = rand_word();
      case (rand_below(5))
        0: access(1'b1, r[3:0], sram_addr(rand_below(32)), rand_word(), "pipe_sram_write");
        1: access(1'b0, 4'hF, sram_addr(rand_below(32)), 32'h0, "pipe_sram_read");
        2: access(1'b1, r[3:0], ctrl_addr(rand_below(2 + NumScratch)), rand_word(),
                  "pipe_ctrl_write");
        3: access(1'b0, 4'hF, ctrl_addr(rand_below(2 + NumScratch)), 32'h0, "pipe_ctrl_read");
        default: access(r[4], r[3:0], r[5] ? {8'h42, r[23:0]} : sram_addr(r[12:8]) + 32'd2,
                        rand_word(), "pipe_error");
      endcase
    end
    drain();
    check_fetch_en("pipe_fetch_en");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* files.f */
src/soc_bus_pkg.sv
src/obi_bus_if.sv
src/addr_decode.sv
src/sram_bank.sv
src/soc_ctrl_regs.sv
src/rsp_mux.sv
src/soc_bus_top.sv
bench/tb_soc_bus.sv

/* src/addr_decode.sv */
// Purely combinational; misaligned, unmapped or out-of-range addresses raise no target request
`timescale 1ns/1ps

module addr_decode #(
  parameter int unsigned SramWords  = 256,
  parameter int unsigned NumScratch = 4
) (
  input  logic                    req_i,
  input  logic                    we_i,
  input  soc_bus_pkg::be_t        be_i,
  input  soc_bus_pkg::addr_t      addr_i,
  input  soc_bus_pkg::data_t      wdata_i,
  output soc_bus_pkg::target_e    target_o,
  obi_bus_if.mgr                  sram_bus,
  obi_bus_if.mgr                  ctrl_bus
);
  import soc_bus_pkg::*;

  addr_u addr;

  assign addr.raw = addr_i;

  // ------------------------------
  // Target selection
  // ------------------------------
  always_comb begin
    target_o = TgtErr;
    if (addr.fields.byte_off == 2'b00) begin
      if (addr.fields.region == SramRegion &&
          32'(addr.fields.word_off) < SramWords) begin
        target_o = TgtSram;
      end else if (addr.fields.region == CtrlRegion &&
                   32'(addr.fields.word_off) < RegScratch0 + NumScratch) begin
        target_o = TgtCtrl;
      end
    end
  end

  // ------------------------------
  // Per-target requests
  // ------------------------------
  // Payload fans out to both, only req is qualified
  assign sram_bus.req   = req_i && (target_o == TgtSram);
  assign sram_bus.we    = we_i;
  assign sram_bus.be    = be_i;
  assign sram_bus.index = addr.fields.word_off;
  assign sram_bus.wdata = wdata_i;

  assign ctrl_bus.req   = req_i && (target_o == TgtCtrl);
  assign ctrl_bus.we    = we_i;
  assign ctrl_bus.be    = be_i;
  assign ctrl_bus.index = addr.fields.word_off;
  assign ctrl_bus.wdata = wdata_i;

endmodule

/* src/obi_bus_if.sv */
// Request and response of one always-ready target; rvalid follows req by exactly one cycle
`timescale 1ns/1ps

interface obi_bus_if;
  import soc_bus_pkg::*;

  // Word index carries bits [31:2] minus the region byte
  localparam int unsigned IdxWidth = AddrWidth - 10;

  // Request side
  logic                req;
  logic                we;
  be_t                 be;
  logic [IdxWidth-1:0] index;
  data_t               wdata;

  // Response side
  logic                rvalid;
  data_t               rdata;

  modport mgr (
    output req,
    output we,
    output be,
    output index,
    output wdata,
    input  rvalid,
    input  rdata
  );

  modport sbr (
    input  req,
    input  we,
    input  be,
    input  index,
    input  wdata,
    output rvalid,
    output rdata
  );

endinterface

/* src/rsp_mux.sv */
// One outstanding response per cycle, no back-pressure; error responses come from here
`timescale 1ns/1ps

module rsp_mux (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  soc_bus_pkg::target_e target_i,
  input  logic                 sram_rvalid_i,
  input  logic                 ctrl_rvalid_i,
  input  soc_bus_pkg::data_t   sram_rdata_i,
  input  soc_bus_pkg::data_t   ctrl_rdata_i,
  output logic                 rvalid_o,
  output logic                 err_o,
  output soc_bus_pkg::data_t   rdata_o
);
  import soc_bus_pkg::*;

  logic    valid_q;
  logic    we_q;
  target_e target_q;

  // Capture the accepted request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      target_q <= TgtErr;
    end else begin
      valid_q  <= req_i;
      we_q     <= we_i;
      target_q <= target_i;
    end
  end

  // ------------------------------
  // Response select
  // ------------------------------
  always_comb begin
    rvalid_o = valid_q;
    err_o    = 1'b0;
    rdata_o  = '0;
    if (valid_q) begin
      case (target_q)
        TgtSram: rdata_o = we_q ? '0 : sram_rdata_i;
        TgtCtrl: rdata_o = we_q ? '0 : ctrl_rdata_i;
        default: begin
          err_o   = 1'b1;
          rdata_o = ErrRspData;
        end
      endcase
    end
  end

  // Targets answer in lockstep with this stage
  a_sram_rvalid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_q && target_q == TgtSram) |-> sram_rvalid_i
  ) else $error("rsp_mux: SRAM response missing");

  a_ctrl_rvalid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_q && target_q == TgtCtrl) |-> ctrl_rvalid_i
  ) else $error("rsp_mux: control register response missing");

endmodule

/* src/soc_bus_pkg.sv */
// Single 32-bit bus, word-aligned accesses only, address region taken from bits [31:24]
package soc_bus_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // Same address word, seen raw or split for decoding
  typedef union packed {
    addr_t raw;
    struct packed {
      logic [7:0]           region;
      logic [AddrWidth-11:0] word_off;
      logic [1:0]           byte_off;
    } fields;
  } addr_u;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam logic [7:0] SramRegion = 8'h10;
  localparam logic [7:0] CtrlRegion = 8'h03;

  // Word offsets inside the control region
  localparam int unsigned RegId       = 0;
  localparam int unsigned RegFetchEn  = 1;
  localparam int unsigned RegScratch0 = 2;

  localparam data_t ChipId     = 32'hC0C0_0001;
  // Read data of any failed access
  localparam data_t ErrRspData = 32'hBADC_AB1E;

  // Destination of one request
  typedef enum logic [1:0] {
    TgtSram,
    TgtCtrl,
    TgtErr
  } target_e;

endpackage

/* src/soc_bus_top.sv */
// Single manager port, always granted; the manager must accept every response when it comes
`timescale 1ns/1ps

module soc_bus_top #(
  parameter int unsigned SramWords  = 256,
  parameter int unsigned NumScratch = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  soc_bus_pkg::be_t   be_i,
  input  soc_bus_pkg::addr_t addr_i,
  input  soc_bus_pkg::data_t wdata_i,
  input  logic               fetch_en_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output soc_bus_pkg::data_t rdata_o,
  output logic               err_o,
  output logic               fetch_en_o
);
  import soc_bus_pkg::*;

  target_e target;

  obi_bus_if sram_bus ();
  obi_bus_if ctrl_bus ();

  // Every target takes a request each cycle
  assign gnt_o = 1'b1;

  // ------------------------------
  // Decode
  // ------------------------------
  addr_decode #(
    .SramWords  ( SramWords  ),
    .NumScratch ( NumScratch )
  ) i_addr_decode (
    .req_i    ( req_i    ),
    .we_i     ( we_i     ),
    .be_i     ( be_i     ),
    .addr_i   ( addr_i   ),
    .wdata_i  ( wdata_i  ),
    .target_o ( target   ),
    .sram_bus ( sram_bus ),
    .ctrl_bus ( ctrl_bus )
  );

  // ------------------------------
  // Targets
  // ------------------------------
  sram_bank #(
    .SramWords ( SramWords )
  ) i_sram_bank (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .bus     ( sram_bus )
  );

  soc_ctrl_regs #(
    .NumScratch ( NumScratch )
  ) i_soc_ctrl (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .fetch_en_i ( fetch_en_i ),
    .bus        ( ctrl_bus   ),
    .fetch_en_o ( fetch_en_o )
  );

  // Response path, error responder included
  rsp_mux i_rsp_mux (
    .clk_i         ( clk_i           ),
    .rst_n_i       ( rst_n_i         ),
    .req_i         ( req_i           ),
    .we_i          ( we_i            ),
    .target_i      ( target          ),
    .sram_rvalid_i ( sram_bus.rvalid ),
    .ctrl_rvalid_i ( ctrl_bus.rvalid ),
    .sram_rdata_i  ( sram_bus.rdata  ),
    .ctrl_rdata_i  ( ctrl_bus.rdata  ),
    .rvalid_o      ( rvalid_o        ),
    .err_o         ( err_o           ),
    .rdata_o       ( rdata_o         )
  );

endmodule

/* src/soc_ctrl_regs.sv */
// Chip ID is read-only, fetch enable is bit 0 only; unused bits read zero
`timescale 1ns/1ps

module soc_ctrl_regs #(
  parameter int unsigned NumScratch = 4
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   fetch_en_i,
  obi_bus_if.sbr bus,
  output logic   fetch_en_o
);
  import soc_bus_pkg::*;

  localparam int unsigned ScrAw = (NumScratch > 1) ? $clog2(NumScratch) : 1;

  logic [31:0]      reg_addr;
  logic             is_scratch;
  logic [ScrAw-1:0] scr_sel;
  logic             fetch_en_q;
  data_t            scratch_q [NumScratch];
  data_t            rdata_d;
  data_t            rdata_q;
  logic             rvalid_q;

  assign reg_addr   = 32'(bus.index);
  assign is_scratch = (reg_addr >= RegScratch0) && (reg_addr < RegScratch0 + NumScratch);
  assign scr_sel    = ScrAw'(reg_addr - RegScratch0);

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_en_q <= 1'b0;
      for (int i = 0; i < NumScratch; i++) begin
        scratch_q[i] <= '0;
      end
    end else if (bus.req && bus.we) begin
      if (reg_addr == RegFetchEn && bus.be[0]) begin
        fetch_en_q <= bus.wdata[0];
      end
      if (is_scratch) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (bus.be[b]) begin
            scratch_q[scr_sel][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
      // Writes to the ID word are dropped
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------
  always_comb begin
    rdata_d = '0;
    if (reg_addr == RegId) begin
      rdata_d = ChipId;
    end else if (reg_addr == RegFetchEn) begin
      rdata_d = {{(DataWidth-1){1'b0}}, fetch_en_q};
    end else if (is_scratch) begin
      rdata_d = scratch_q[scr_sel];
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  // Pin or register starts the core
  assign fetch_en_o = fetch_en_i | fetch_en_q;

endmodule

/* src/sram_bank.sv */
// Read data valid one cycle after req; contents undefined until written; SramWords >= 2
`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned SramWords = 256
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr bus
);
  import soc_bus_pkg::*;

  localparam int unsigned SramAw = $clog2(SramWords);

  data_t              mem [SramWords];
  data_t              rdata_q;
  logic               rvalid_q;
  logic [SramAw-1:0]  word_idx;

  // Decoder keeps the upper index bits at zero
  assign word_idx = bus.index[SramAw-1:0];

  // ------------------------------
  // Memory array
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (bus.be[b]) begin
            mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  // Response valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  // Range check lives in the decoder
  a_idx_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    bus.req |-> (32'(bus.index) < SramWords)
  ) else $error("sram_bank: index out of range");

endmodule
